//--- run_sim.sh
#!/bin/sh
# build and run the configuration testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
  --top-module tb_cfg_link -o tb_cfg_link
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_cfg_link > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
  echo "no closing message found in $LOG"
  exit 1
fi
exit 0

//--- sim.f
source/pcie_cfg_pkg.sv
source/ts_rx_decoder.sv
source/cfg_fsm.sv
source/os_tx_framer.sv
source/cfg_link_top.sv
verif/cfg_checker.sv
verif/tb_cfg_link.sv

//--- source/cfg_fsm.sv
`timescale 1ns/1ps

module cfg_fsm #(
  parameter int NUM_LANES = 4,
  parameter int LINK_NUM = 0,
  parameter int TIMEOUT_LONG = 3_000_000,
  parameter int TIMEOUT_SHORT = 250_000
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     en_i,
  input  pcie_cfg_pkg::rx_status_t status_i,
  output logic                     send_req_o,
  output pcie_cfg_pkg::tx_os_t     tx_os_o,
  input  logic                     busy_i,
  input  logic                     done_i,
  output logic                     clear_o,
  output logic [NUM_LANES-1:0]     formed_o,
  output logic                     success_o,
  output logic                     error_o
);
  import pcie_cfg_pkg::*;

  localparam int TM_W = $clog2(TIMEOUT_LONG + 1);
  localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int SENT_W = $clog2(IDLE_TX_MIN + 1);

  cfg_state_e           state_q;
  cfg_state_e           state_d;
  logic [TM_W-1:0]      timer_q;
  logic [NUM_LANES-1:0] formed_q;
  logic [NUM_LANES-1:0] formed_d;
  logic [NUM_LANES-1:0] run_mask;
  logic [IDX_W-1:0]     lane_idx_q;
  logic [IDX_W-1:0]     lane_idx_d;
  logic [SENT_W-1:0]    idle_sent_q;
  logic [SENT_W-1:0]    idle_sent_d;
  logic                 success_q;
  logic                 success_d;
  logic                 error_q;
  logic                 error_d;
  logic                 wait_q;
  logic                 sending;
  logic                 more_lanes;
  logic                 long_expired;
  logic                 short_expired;

  // lanes that answered, counted from lane 0 up to the first gap
  function automatic logic [NUM_LANES-1:0] lead_run(logic [NUM_LANES-1:0] mask);
    logic [NUM_LANES-1:0] run;
    logic                 open;
    open = 1'b1;
    for (int i = 0; i < NUM_LANES; i++) begin
      open = open & mask[i];
      run[i] = open;
    end
    return run;
  endfunction

  function automatic logic covers(logic [MAX_LANES-1:0] mask, logic [NUM_LANES-1:0] lanes);
    return (mask[NUM_LANES-1:0] & lanes) == lanes;
  endfunction

  assign run_mask = lead_run(status_i.link_ok[NUM_LANES-1:0]);
  assign long_expired = (timer_q >= TM_W'(TIMEOUT_LONG));
  assign short_expired = (timer_q >= TM_W'(TIMEOUT_SHORT));
  // formed lanes are contiguous, so any bit above means another lane
  assign more_lanes = |(formed_q >> (32'(lane_idx_q) + 1));

  assign sending = state_q inside {ST_LW_START, ST_LN_WAIT, ST_LN_ACCEPT, ST_COMPLETE,
                                   ST_CFG_IDLE};
  assign send_req_o = sending && !busy_i && !wait_q;

  always_comb begin
    tx_os_o.kind = OS_TS1;
    tx_os_o.link_num = 8'(LINK_NUM);
    tx_os_o.lane_num = 8'(lane_idx_q);
    tx_os_o.lane_pad = 1'b0;
    case (state_q)
      ST_LW_START: tx_os_o.lane_pad = 1'b1;
      ST_COMPLETE: tx_os_o.kind = OS_TS2;
      ST_CFG_IDLE: tx_os_o.kind = OS_IDLE;
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    formed_d = formed_q;
    lane_idx_d = lane_idx_q;
    idle_sent_d = idle_sent_q;
    success_d = success_q;
    error_d = error_q;
    // step through the formed lanes, one set per lane number
    if (done_i) begin
      lane_idx_d = more_lanes ? lane_idx_q + 1'b1 : '0;
    end
    case (state_q)
      ST_IDLE: begin
        formed_d = '0;
        if (en_i) begin
          state_d = ST_LW_START;
        end
      end
      ST_LW_START: begin
        if (done_i) begin
          if (|status_i.link_ok) begin
            state_d = ST_LW_ACCEPT;
          end else if (long_expired) begin
            error_d = 1'b1;
            state_d = ST_WAIT_EN_LOW;
          end
        end
      end
      ST_LW_ACCEPT: begin
        formed_d = run_mask;
        if (run_mask[0]) begin
          state_d = ST_LN_WAIT;
        end else begin
          // lane 0 never echoed, no link can be formed
          error_d = 1'b1;
          state_d = ST_WAIT_EN_LOW;
        end
      end
      ST_LN_WAIT: begin
        if (done_i && !more_lanes) begin
          state_d = ST_LN_ACCEPT;
        end
      end
      ST_LN_ACCEPT: begin
        if (done_i) begin
          if (covers(status_i.lane_ok, formed_q)) begin
            state_d = ST_COMPLETE;
          end else if (short_expired) begin
            error_d = 1'b1;
            state_d = ST_WAIT_EN_LOW;
          end
        end
      end
      ST_COMPLETE: begin
        if (done_i) begin
          if (covers(status_i.ts2_ok, formed_q)) begin
            state_d = ST_CFG_IDLE;
          end else if (short_expired) begin
            error_d = 1'b1;
            state_d = ST_WAIT_EN_LOW;
          end
        end
      end
      ST_CFG_IDLE: begin
        if (done_i) begin
          if (idle_sent_q < SENT_W'(IDLE_TX_MIN)) begin
            idle_sent_d = idle_sent_q + 1'b1;
          end
          // this done completes one more idle set
          if (status_i.idle_ok && (idle_sent_q >= SENT_W'(IDLE_TX_MIN - 1))) begin
            success_d = 1'b1;
            state_d = ST_WAIT_EN_LOW;
          end else if (short_expired) begin
            error_d = 1'b1;
            state_d = ST_WAIT_EN_LOW;
          end
        end
      end
      ST_WAIT_EN_LOW: begin
        if (!en_i) begin
          success_d = 1'b0;
          error_d = 1'b0;
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
    if (state_d != state_q) begin
      lane_idx_d = '0;
      idle_sent_d = '0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      timer_q     <= '0;
      formed_q    <= '0;
      lane_idx_q  <= '0;
      idle_sent_q <= '0;
      success_q   <= 1'b0;
      error_q     <= 1'b0;
      wait_q      <= 1'b0;
    end else begin
      state_q     <= state_d;
      formed_q    <= formed_d;
      lane_idx_q  <= lane_idx_d;
      idle_sent_q <= idle_sent_d;
      success_q   <= success_d;
      error_q     <= error_d;
      if (state_d != state_q) begin
        timer_q <= '0;
      end else if (!long_expired) begin
        timer_q <= timer_q + 1'b1;
      end
      if (send_req_o) begin
        wait_q <= 1'b1;
      end else if (done_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  assign clear_o = (state_q == ST_IDLE);
  assign formed_o = formed_q;
  assign success_o = success_q;
  assign error_o = error_q;

  a_result_excl: assert property (
    @(posedge clk_i) disable iff (rst_i) !(success_o && error_o)
  );

  // framer completion must answer a request of ours
  a_done_owned: assert property (
    @(posedge clk_i) disable iff (rst_i) done_i |-> wait_q
  );

endmodule

//--- source/cfg_link_top.sv
`timescale 1ns/1ps

module cfg_link_top #(
  parameter int NUM_LANES = 4,
  parameter int LINK_NUM = 0,
  // 24 ms and 2 ms at a 125 MHz clock
  parameter int TIMEOUT_LONG = 3_000_000,
  parameter int TIMEOUT_SHORT = 250_000
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   en_i,
  input  pcie_cfg_pkg::rx_os_t   rx_os_i [NUM_LANES],
  output logic [31:0]            m_tdata_o,
  output logic [3:0]             m_tkeep_o,
  output logic                   m_tvalid_o,
  output logic                   m_tlast_o,
  output pcie_cfg_pkg::os_kind_e m_tuser_o,
  input  logic                   m_tready_i,
  output logic                   success_o,
  output logic                   error_o,
  output logic [NUM_LANES-1:0]   link_width_o
);
  import pcie_cfg_pkg::*;

  rx_status_t           status;
  tx_os_t               tx_os;
  logic                 send_req;
  logic                 busy;
  logic                 done;
  logic                 clear;
  logic [NUM_LANES-1:0] formed;

  ts_rx_decoder #(
    .NUM_LANES(NUM_LANES),
    .LINK_NUM (LINK_NUM)
  ) u_decoder (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (clear),
    .formed_i(formed),
    .rx_os_i (rx_os_i),
    .status_o(status)
  );

  cfg_fsm #(
    .NUM_LANES    (NUM_LANES),
    .LINK_NUM     (LINK_NUM),
    .TIMEOUT_LONG (TIMEOUT_LONG),
    .TIMEOUT_SHORT(TIMEOUT_SHORT)
  ) u_fsm (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .en_i      (en_i),
    .status_i  (status),
    .send_req_o(send_req),
    .tx_os_o   (tx_os),
    .busy_i    (busy),
    .done_i    (done),
    .clear_o   (clear),
    .formed_o  (formed),
    .success_o (success_o),
    .error_o   (error_o)
  );

  os_tx_framer #(
    .NUM_LANES(NUM_LANES)
  ) u_framer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .send_req_i(send_req),
    .os_i      (tx_os),
    .busy_o    (busy),
    .done_o    (done),
    .m_tdata_o (m_tdata_o),
    .m_tkeep_o (m_tkeep_o),
    .m_tvalid_o(m_tvalid_o),
    .m_tlast_o (m_tlast_o),
    .m_tuser_o (m_tuser_o),
    .m_tready_i(m_tready_i)
  );

  assign link_width_o = formed;

endmodule

//--- source/os_tx_framer.sv
`timescale 1ns/1ps

module os_tx_framer #(
  parameter int NUM_LANES = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   send_req_i,
  input  pcie_cfg_pkg::tx_os_t   os_i,
  output logic                   busy_o,
  output logic                   done_o,
  output logic [31:0]            m_tdata_o,
  output logic [3:0]             m_tkeep_o,
  output logic                   m_tvalid_o,
  output logic                   m_tlast_o,
  output pcie_cfg_pkg::os_kind_e m_tuser_o,
  input  logic                   m_tready_i
);
  import pcie_cfg_pkg::*;

  tx_os_t     os_q;
  logic [1:0] idx_q;
  logic       act_q;
  logic       done_q;
  logic       start;

  assign start = send_req_i && !act_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      act_q  <= 1'b0;
      idx_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        act_q <= 1'b1;
        idx_q <= '0;
      end else if (act_q && m_tready_i) begin
        idx_q <= idx_q + 1'b1;
        // last word accepted
        if (idx_q == 2'd3) begin
          act_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      os_q <= os_i;
    end
  end

  assign busy_o = act_q;
  assign done_o = done_q;
  assign m_tvalid_o = act_q;
  assign m_tkeep_o = {4{act_q}};
  assign m_tdata_o = os_word(os_q, idx_q);
  assign m_tlast_o = (idx_q == 2'd3);
  assign m_tuser_o = os_q.kind;

  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (m_tvalid_o && !m_tready_i) |=>
      (m_tvalid_o && $stable(m_tdata_o) && $stable(m_tlast_o) && $stable(m_tuser_o))
  );

  a_no_req_busy: assert property (
    @(posedge clk_i) disable iff (rst_i) send_req_i |-> !busy_o
  );

  // numbered sets may only name a lane that exists
  a_lane_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (send_req_i && (os_i.kind != OS_IDLE) && !os_i.lane_pad) |-> (os_i.lane_num < NUM_LANES)
  );

endmodule

//--- source/pcie_cfg_pkg.sv
package pcie_cfg_pkg;

  // upper bound on link width
  localparam int MAX_LANES = 4;

  // consecutive matching sets needed per lane
  localparam int TS1_REQ = 2;
  localparam int TS2_REQ = 8;
  localparam int IDLE_REQ = 8;
  // idle sets that must go out before success
  localparam int IDLE_TX_MIN = 16;

  localparam logic [7:0] SYM_COM = 8'hBC;
  localparam logic [7:0] SYM_PAD = 8'hF7;
  localparam logic [7:0] ID_TS1 = 8'h4A;
  localparam logic [7:0] ID_TS2 = 8'h45;
  localparam logic [7:0] N_FTS = 8'h10;

  typedef enum logic [1:0] {
    OS_TS1,
    OS_TS2,
    OS_IDLE
  } os_kind_e;

  typedef struct packed {
    logic       valid;
    os_kind_e   kind;
    logic [7:0] link_num;
    logic [7:0] lane_num;
    logic       lane_pad;
  } rx_os_t;

  typedef struct packed {
    os_kind_e   kind;
    logic [7:0] link_num;
    logic [7:0] lane_num;
    logic       lane_pad;
  } tx_os_t;

  typedef struct packed {
    logic [MAX_LANES-1:0] link_ok;
    logic [MAX_LANES-1:0] lane_ok;
    logic [MAX_LANES-1:0] ts2_ok;
    logic                 idle_ok;
  } rx_status_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LW_START,
    ST_LW_ACCEPT,
    ST_LN_WAIT,
    ST_LN_ACCEPT,
    ST_COMPLETE,
    ST_CFG_IDLE,
    ST_WAIT_EN_LOW
  } cfg_state_e;

  // word 0 is COM, link, lane, N_FTS; words 1..3 repeat the identifier
  function automatic logic [31:0] os_word(tx_os_t os, logic [1:0] idx);
    logic [7:0] lane_sym;
    logic [7:0] id_sym;
    lane_sym = os.lane_pad ? SYM_PAD : os.lane_num;
    id_sym = (os.kind == OS_TS2) ? ID_TS2 : ID_TS1;
    if (os.kind == OS_IDLE) begin
      return '0;
    end
    if (idx == 2'd0) begin
      return {SYM_COM, os.link_num, lane_sym, N_FTS};
    end
    return {4{id_sym}};
  endfunction

endpackage

//--- source/ts_rx_decoder.sv
`timescale 1ns/1ps

module ts_rx_decoder #(
  parameter int NUM_LANES = 4,
  parameter int LINK_NUM = 0
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     clear_i,
  input  logic [NUM_LANES-1:0]     formed_i,
  input  pcie_cfg_pkg::rx_os_t     rx_os_i [NUM_LANES],
  output pcie_cfg_pkg::rx_status_t status_o
);
  import pcie_cfg_pkg::*;

  localparam int MAX_TS = (TS1_REQ > TS2_REQ) ? TS1_REQ : TS2_REQ;
  localparam int CNT_MAX = (MAX_TS > IDLE_REQ) ? MAX_TS : IDLE_REQ;
  localparam int CNT_W = $clog2(CNT_MAX + 1);

  logic [NUM_LANES-1:0] link_mask;
  logic [NUM_LANES-1:0] lane_mask;
  logic [NUM_LANES-1:0] ts2_mask;
  logic [NUM_LANES-1:0] idle_mask;

  // saturating run counter; a strobe that misses restarts the run
  function automatic logic [CNT_W-1:0] step(logic [CNT_W-1:0] cnt, logic strobe,
                                            logic hit, int lim);
    if (!strobe) begin
      return cnt;
    end
    if (!hit) begin
      return '0;
    end
    return (cnt < CNT_W'(lim)) ? cnt + 1'b1 : cnt;
  endfunction

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    logic [CNT_W-1:0] link_cnt;
    logic [CNT_W-1:0] lane_cnt;
    logic [CNT_W-1:0] ts2_cnt;
    logic [CNT_W-1:0] idle_cnt;
    logic             stb;
    logic             link_hit;
    logic             lane_hit;
    logic             is_ts1;

    assign stb = rx_os_i[i].valid;
    assign is_ts1 = (rx_os_i[i].kind == OS_TS1);
    assign link_hit = (rx_os_i[i].link_num == 8'(LINK_NUM));
    // partner must return this lane's own number, not PAD
    assign lane_hit = link_hit && !rx_os_i[i].lane_pad && (rx_os_i[i].lane_num == 8'(i));

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        link_cnt <= '0;
        lane_cnt <= '0;
        ts2_cnt  <= '0;
        idle_cnt <= '0;
      end else if (clear_i) begin
        link_cnt <= '0;
        lane_cnt <= '0;
        ts2_cnt  <= '0;
        idle_cnt <= '0;
      end else begin
        link_cnt <= step(link_cnt, stb, is_ts1 && link_hit, TS1_REQ);
        lane_cnt <= step(lane_cnt, stb, is_ts1 && lane_hit, TS1_REQ);
        ts2_cnt  <= step(ts2_cnt, stb, (rx_os_i[i].kind == OS_TS2) && lane_hit, TS2_REQ);
        idle_cnt <= step(idle_cnt, stb, rx_os_i[i].kind == OS_IDLE, IDLE_REQ);
      end
    end

    assign link_mask[i] = (link_cnt >= CNT_W'(TS1_REQ));
    assign lane_mask[i] = (lane_cnt >= CNT_W'(TS1_REQ));
    assign ts2_mask[i]  = (ts2_cnt >= CNT_W'(TS2_REQ));
    assign idle_mask[i] = (idle_cnt >= CNT_W'(IDLE_REQ));

    // the symbol decoder upstream only hands over known set types
    a_kind_known: assert property (
      @(posedge clk_i) disable iff (rst_i)
      rx_os_i[i].valid |-> (rx_os_i[i].kind inside {OS_TS1, OS_TS2, OS_IDLE})
    );
  end

  always_comb begin
    status_o = '0;
    status_o.link_ok = MAX_LANES'(link_mask);
    status_o.lane_ok = MAX_LANES'(lane_mask);
    // ts2 and idle only count on lanes that made it into the link
    status_o.ts2_ok = MAX_LANES'(ts2_mask & formed_i);
    status_o.idle_ok = (|formed_i) && ((idle_mask & formed_i) == formed_i);
  end

endmodule

//--- verif/cfg_checker.sv
`timescale 1ns/1ps

module cfg_checker #(
  parameter int NUM_LANES = 4,
  parameter int LINK_NUM = 0
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   en_i,
  input  logic [31:0]            m_tdata_i,
  input  logic [3:0]             m_tkeep_i,
  input  logic                   m_tvalid_i,
  input  logic                   m_tlast_i,
  input  pcie_cfg_pkg::os_kind_e m_tuser_i,
  input  logic                   m_tready_i,
  input  logic                   success_i,
  input  logic                   error_i,
  input  logic [NUM_LANES-1:0]   link_width_i,
  input  logic [NUM_LANES-1:0]   ans_mask_i,
  input  logic                   lane_good_i,
  output int                     err_count_o
);
  import pcie_cfg_pkg::*;

  // frame phases in the order they go out
  localparam int PH_PAD = 0;
  localparam int PH_NUM = 1;
  localparam int PH_TS2 = 2;
  localparam int PH_IDLE = 3;

  int          errors = 0;
  int          phase = 0;
  int          lane_cnt = 0;
  int          word_idx = 0;
  int          idle_frames = 0;
  logic        result_seen = 1'b0;
  logic        en_prev = 1'b0;
  logic        stalled = 1'b0;
  logic [31:0] held_data = '0;
  logic        held_last = 1'b0;
  os_kind_e    held_user = OS_TS1;

  assign err_count_o = errors;

  function automatic logic [31:0] ref_word(int ph, int lane, int idx);
    logic [7:0] id;
    logic [7:0] lane_sym;
    id = (ph == PH_TS2) ? ID_TS2 : ID_TS1;
    lane_sym = (ph == PH_PAD) ? SYM_PAD : 8'(lane);
    if (ph == PH_IDLE) begin
      return 32'h0;
    end
    if (idx == 0) begin
      return {SYM_COM, 8'(LINK_NUM), lane_sym, 8'h10};
    end
    return {id, id, id, id};
  endfunction

  function automatic os_kind_e ref_kind(int ph);
    if (ph == PH_IDLE) begin
      return OS_IDLE;
    end
    return (ph == PH_TS2) ? OS_TS2 : OS_TS1;
  endfunction

  // echoing lanes from lane 0 up to the first silent one
  function automatic logic [NUM_LANES-1:0] ref_width(logic [NUM_LANES-1:0] ans);
    int n;
    n = 0;
    while (n < NUM_LANES && ans[n]) begin
      n++;
    end
    return NUM_LANES'((1 << n) - 1);
  endfunction

  function automatic int ref_last_phase(logic [NUM_LANES-1:0] ans, logic good);
    if (ref_width(ans) == '0) begin
      return PH_PAD;
    end
    return good ? PH_IDLE : PH_NUM;
  endfunction

  task automatic report_value(string name, logic [31:0] exp, logic [31:0] act);
    errors++;
    $display("ERROR at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
  endtask

  task automatic report_fail(string msg);
    errors++;
    $display("FAILURE at %0t: %s", $time, msg);
  endtask

  task automatic check_word();
    int          ph;
    int          width;
    logic [31:0] exp;
    if (word_idx == 0) begin
      if (m_tuser_i == OS_IDLE) ph = PH_IDLE;
      else if (m_tuser_i == OS_TS2) ph = PH_TS2;
      else if (m_tdata_i[15:8] == SYM_PAD) ph = PH_PAD;
      else ph = PH_NUM;
      if (ph == phase + 1) begin
        phase = ph;
        lane_cnt = 0;
      end else if (ph != phase) begin
        report_fail($sformatf("frame of phase %0d sent while in phase %0d", ph, phase));
      end
    end
    exp = ref_word(phase, lane_cnt, word_idx);
    if (m_tdata_i != exp) report_value("m_tdata_o", exp, m_tdata_i);
    if (m_tuser_i != ref_kind(phase)) begin
      report_value("m_tuser_o", 32'(ref_kind(phase)), 32'(m_tuser_i));
    end
    if (m_tlast_i != (word_idx == 3)) begin
      report_value("m_tlast_o", 32'(word_idx == 3), 32'(m_tlast_i));
    end
    if (m_tkeep_i != 4'hF) report_value("m_tkeep_o", 32'hF, 32'(m_tkeep_i));
    if (word_idx == 3) begin
      width = $countones(ref_width(ans_mask_i));
      // numbered sets walk through the formed lanes
      if (phase == PH_NUM || phase == PH_TS2) begin
        lane_cnt = (width > 0) ? (lane_cnt + 1) % width : 0;
      end
      if (phase == PH_IDLE) idle_frames++;
      word_idx = 0;
    end else begin
      word_idx++;
    end
  endtask

  task automatic check_result();
    logic [NUM_LANES-1:0] exp_w;
    logic                 exp_ok;
    exp_w = ref_width(ans_mask_i);
    exp_ok = (exp_w != '0) && lane_good_i;
    if (success_i != exp_ok) report_value("success_o", 32'(exp_ok), 32'(success_i));
    if (error_i != !exp_ok) report_value("error_o", 32'(!exp_ok), 32'(error_i));
    if (link_width_i != exp_w) report_value("link_width_o", 32'(exp_w), 32'(link_width_i));
    if (phase != ref_last_phase(ans_mask_i, lane_good_i)) begin
      report_fail($sformatf("run ended in phase %0d, expected phase %0d", phase,
                            ref_last_phase(ans_mask_i, lane_good_i)));
    end
    if (exp_ok && idle_frames < IDLE_TX_MIN) begin
      report_fail($sformatf("success after only %0d idle frames", idle_frames));
    end
  endtask

  // stream and result monitor on the falling edge
  always @(negedge clk_i) begin
    if (rst_i || !en_i) begin
      if (!rst_i && !en_prev && (success_i || error_i)) begin
        report_fail("result level still high after en_i went low");
      end
      if (!rst_i && !en_prev && m_tvalid_i) begin
        report_fail("stream active while link training is disabled");
      end
      phase = PH_PAD;
      lane_cnt = 0;
      word_idx = 0;
      idle_frames = 0;
      result_seen = 1'b0;
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        if (!m_tvalid_i) begin
          report_fail("valid dropped while the sink was stalling");
        end else begin
          if (m_tdata_i != held_data) report_value("m_tdata_o", held_data, m_tdata_i);
          if (m_tlast_i != held_last) report_value("m_tlast_o", 32'(held_last), 32'(m_tlast_i));
          if (m_tuser_i != held_user) report_value("m_tuser_o", 32'(held_user), 32'(m_tuser_i));
        end
      end
      stalled = m_tvalid_i && !m_tready_i;
      held_data = m_tdata_i;
      held_last = m_tlast_i;
      held_user = m_tuser_i;
      if (!m_tvalid_i && word_idx != 0) begin
        report_fail("frame ended before its fourth word");
        word_idx = 0;
      end
      if (m_tvalid_i && m_tready_i) check_word();
      if ((success_i || error_i) && !result_seen) begin
        result_seen = 1'b1;
        check_result();
      end
    end
    en_prev = en_i;
  end

endmodule

//--- verif/tb_cfg_link.sv
`timescale 1ns/1ps

module tb_cfg_link;
  import pcie_cfg_pkg::*;

  localparam int NUM_LANES = 4;
  localparam int LINK_NUM = 0;
  localparam int TIMEOUT_LONG = 2000;
  localparam int TIMEOUT_SHORT = 400;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RUNS = 7;
  localparam int RUN_LIMIT = TIMEOUT_LONG + 4 * TIMEOUT_SHORT;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_LIMIT + RESET_CYCLES;

  logic                 clk = 1'b0;
  logic                 rst = 1'b1;
  logic                 en = 1'b0;
  rx_os_t               rx_os [NUM_LANES] = '{default: '0};
  logic [31:0]          m_tdata;
  logic [3:0]           m_tkeep;
  logic                 m_tvalid;
  logic                 m_tlast;
  os_kind_e             m_tuser;
  logic                 m_tready = 1'b1;
  logic                 success;
  logic                 failure;
  logic [NUM_LANES-1:0] link_width;
  // partner setup for the current run
  logic [NUM_LANES-1:0] ans_mask = '0;
  logic                 lane_good = 1'b1;
  logic                 stall_on = 1'b0;
  logic                 mid_frame = 1'b0;
  logic                 frame_pad = 1'b0;
  int                   chk_errors;
  int                   tb_errors = 0;

  always #50 clk = ~clk;

  cfg_link_top #(
    .NUM_LANES    (NUM_LANES),
    .LINK_NUM     (LINK_NUM),
    .TIMEOUT_LONG (TIMEOUT_LONG),
    .TIMEOUT_SHORT(TIMEOUT_SHORT)
  ) dut0 (
    .clk_i       (clk),
    .rst_i       (rst),
    .en_i        (en),
    .rx_os_i     (rx_os),
    .m_tdata_o   (m_tdata),
    .m_tkeep_o   (m_tkeep),
    .m_tvalid_o  (m_tvalid),
    .m_tlast_o   (m_tlast),
    .m_tuser_o   (m_tuser),
    .m_tready_i  (m_tready),
    .success_o   (success),
    .error_o     (failure),
    .link_width_o(link_width)
  );

  cfg_checker #(
    .NUM_LANES(NUM_LANES),
    .LINK_NUM (LINK_NUM)
  ) chk0 (
    .clk_i       (clk),
    .rst_i       (rst),
    .en_i        (en),
    .m_tdata_i   (m_tdata),
    .m_tkeep_i   (m_tkeep),
    .m_tvalid_i  (m_tvalid),
    .m_tlast_i   (m_tlast),
    .m_tuser_i   (m_tuser),
    .m_tready_i  (m_tready),
    .success_i   (success),
    .error_i     (failure),
    .link_width_i(link_width),
    .ans_mask_i  (ans_mask),
    .lane_good_i (lane_good),
    .err_count_o (chk_errors)
  );

  always @(posedge clk) begin
    #5;
    m_tready = stall_on ? (($urandom % 4) != 0) : 1'b1;
  end

  // partner lanes answer one set per frame, one cycle strobe
  task automatic answer_set(input os_kind_e kind, input logic pad);
    @(posedge clk);
    #5;
    for (int i = 0; i < NUM_LANES; i++) begin
      rx_os[i] = '0;
      if (ans_mask[i]) begin
        rx_os[i].valid = 1'b1;
        rx_os[i].kind = kind;
        rx_os[i].link_num = 8'(LINK_NUM);
        if (kind != OS_IDLE) begin
          rx_os[i].lane_pad = pad;
          rx_os[i].lane_num = pad ? SYM_PAD : (lane_good ? 8'(i) : 8'(NUM_LANES - 1 - i));
        end
      end
    end
    @(posedge clk);
    #5;
    for (int i = 0; i < NUM_LANES; i++) begin
      rx_os[i] = '0;
    end
  endtask

  always @(negedge clk) begin
    if (m_tvalid && m_tready) begin
      if (!mid_frame) frame_pad = (m_tdata[15:8] == SYM_PAD);
      mid_frame = !m_tlast;
      if (m_tlast) answer_set(m_tuser, frame_pad);
    end
  end

  task automatic run_link(input logic [NUM_LANES-1:0] ans, input logic good, input logic stall);
    int waited;
    ans_mask = ans;
    lane_good = good;
    stall_on = stall;
    waited = 0;
    @(posedge clk);
    #5;
    en = 1'b1;
    while (!(success || failure) && waited < RUN_LIMIT) begin
      @(posedge clk);
      #5;
      waited++;
    end
    if (waited >= RUN_LIMIT) begin
      tb_errors++;
      $display("link training gave no result within %0d cycles", RUN_LIMIT);
    end
    repeat (4) @(posedge clk);
    #5;
    en = 1'b0;
    repeat (4) @(posedge clk);
  endtask

  initial begin
    void'($urandom(32'he794));
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    rst = 1'b0;
    run_link(4'b1111, 1'b1, 1'b0);
    // gaps in the answering lanes
    run_link(4'b0111, 1'b1, 1'b0);
    run_link(4'b1011, 1'b1, 1'b0);
    // silent partner, then a clean retry
    run_link(4'b0000, 1'b1, 1'b0);
    run_link(4'b1111, 1'b1, 1'b0);
    run_link(4'b1111, 1'b0, 1'b0);
    run_link(4'b1111, 1'b1, 1'b1);
    @(negedge clk);
    $display("checker errors: %0d, testbench errors: %0d", chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule
